// File: cpuIsa.sv
package cpuIsa;

        typedef enum logic [4:0] {
                ld, ldi, st, add, sub, andOp, orOp,
                shr, shra, shl, ror, rol,
                addi, andi, ori, neg, notOp,
                br, outOp, halt
        } opcode_e;

        // br reads this from the low bits of rb
        typedef enum logic [1:0] {
                condZero, condNonzero, condPlus, condMinus
        } brCond_e;

        typedef struct packed {
                opcode_e op;
                logic [3:0] ra;
                logic [3:0] rb;
                logic [3:0] rc;
                logic [14:0] unused;
        } rForm_t;

        typedef struct packed {
                opcode_e op;
                logic [3:0] ra;
                logic [3:0] rb;
                logic [18:0] imm;       // two's complement constant
        } iForm_t;

        typedef union packed {
                rForm_t rForm;
                iForm_t iForm;
        } instrWord_u;

endpackage

// File: cpuCtrl.sv
package cpuCtrl;

        // bit 3 set means the shifter feeds Z
        typedef enum logic [3:0] {
                selAdd  = 4'b0000,
                selSub  = 4'b0001,
                selAnd  = 4'b0010,
                selOr   = 4'b0011,
                selNeg  = 4'b0100,
                selNot  = 4'b0101,
                selShr  = 4'b1000,
                selShra = 4'b1001,
                selShl  = 4'b1010,
                selRor  = 4'b1011,
                selRol  = 4'b1100
        } aluSel_e;

        typedef struct packed {
                logic pcOut, zLowOut, mdrOut, rOut, cOut;       // bus drivers
                logic gra, grb, grc, baOut;
                logic rIn, marIn, mdrIn, pcIn, irIn, yIn, zIn;
                logic incPc, read, write, conIn, outIn;
                aluSel_e aluSel;
        } ctrlWord_t;

endpackage

// File: regFile.sv
`timescale 1ns/1ps
module regFile (
        input  logic Clock,
        input  logic rst,
        input  cpuIsa::instrWord_u ir,
        input  logic gra,
        input  logic grb,
        input  logic grc,
        input  logic rIn,
        input  logic rOut,
        input  logic baOut,
        input  logic [31:0] busIn,
        output logic [31:0] busOut
);

        logic [31:0] regs [16];
        logic [3:0] sel;

        // field select out of the IR
        always_comb begin
                sel = 4'd0;
                if (gra)
                        sel = ir.rForm.ra;
                else if (grb)
                        sel = ir.rForm.rb;
                else if (grc)
                        sel = ir.rForm.rc;
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < 16; i++)
                                regs[i] <= '0;
                end else if (rIn) begin
                        regs[sel] <= busIn;
                end
        end

        always_comb begin
                busOut = '0;
                if ((rOut || baOut) && !(baOut && sel == 4'd0))  // R0 as base is zero
                        busOut = regs[sel];
        end

endmodule

// File: aluUnit.sv
`timescale 1ns/1ps
module aluUnit (
        input  logic [31:0] yVal,
        input  logic [31:0] busVal,
        input  cpuCtrl::aluSel_e aluSel,
        input  logic incPc,
        output logic [31:0] result
);
        import cpuCtrl::*;

        always_comb begin
                if (incPc) begin
                        result = busVal + 32'd1;        // PC + 1 during fetch
                end else begin
                        case (aluSel)
                                selAdd:
                                        result = yVal + busVal;
                                selSub:
                                        result = yVal - busVal;
                                selAnd:
                                        result = yVal & busVal;
                                selOr:
                                        result = yVal | busVal;
                                selNeg:
                                        result = -busVal;
                                selNot:
                                        result = ~busVal;
                                default:
                                        result = '0;    // shift codes
                        endcase
                end
        end

endmodule

// File: shiftUnit.sv
`timescale 1ns/1ps
module shiftUnit (
        input  logic [31:0] yVal,
        input  logic [31:0] busVal,
        input  cpuCtrl::aluSel_e aluSel,
        output logic [31:0] result
);
        import cpuCtrl::*;

        logic [4:0] amt;
        logic [63:0] rotR;
        logic [63:0] rotL;

        assign amt = busVal[4:0];
        // doubled word makes the rotates plain shifts
        assign rotR = {yVal, yVal} >> amt;
        assign rotL = {yVal, yVal} << amt;

        always_comb begin
                case (aluSel)
                        selShr:
                                result = yVal >> amt;
                        selShra:
                                result = $signed(yVal) >>> amt;
                        selShl:
                                result = yVal << amt;
                        selRor:
                                result = rotR[31:0];
                        selRol:
                                result = rotL[63:32];
                        default:
                                result = '0;
                endcase
        end

endmodule

// File: ramBlock.sv
`timescale 1ns/1ps
module ramBlock #(
        parameter int MEM_DEPTH = 256
) (
        input  logic Clock,
        input  logic rst,
        input  logic [$clog2(MEM_DEPTH)-1:0] addr,
        input  logic [31:0] wData,
        input  logic write,
        output logic [31:0] rData,
        input  logic loadEn,
        input  logic [$clog2(MEM_DEPTH)-1:0] loadAddr,
        input  logic [31:0] loadData
);

        logic [31:0] mem [MEM_DEPTH];

        assign rData = mem[addr];

        always_ff @(posedge Clock) begin
                if (rst) begin
                        if (loadEn)
                                mem[loadAddr] <= loadData;      // program load while held
                end else if (write) begin
                        mem[addr] <= wData;
                end
        end

endmodule

// File: dataPath.sv
`timescale 1ns/1ps
module dataPath #(
        parameter int MEM_DEPTH = 256
) (
        input  logic Clock,
        input  logic rst,
        input  cpuCtrl::ctrlWord_t ctrl,
        output cpuIsa::instrWord_u ir,
        output logic [$clog2(MEM_DEPTH)-1:0] memAddr,
        output logic [31:0] memWData,
        input  logic [31:0] memRData,
        output logic [31:0] outPort,
        output logic outStrobe
);
        import cpuIsa::*;

        localparam int ADDR_W = $clog2(MEM_DEPTH);

        logic [31:0] bus;
        logic [31:0] pc;
        logic [ADDR_W-1:0] mar;
        logic [31:0] mdr;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] regBus;
        logic [31:0] aluRes;
        logic [31:0] shiftRes;
        logic [31:0] cExt;
        brCond_e cond;
        logic condMet;
        logic brFlag;

        assign cExt = {{13{ir.iForm.imm[18]}}, ir.iForm.imm};
        assign cond = brCond_e'(ir.iForm.rb[1:0]);
        assign memAddr = mar;
        assign memWData = mdr;

        // one source on the bus per step
        always_comb begin
                if (ctrl.pcOut)
                        bus = pc;
                else if (ctrl.zLowOut)
                        bus = z;
                else if (ctrl.mdrOut)
                        bus = mdr;
                else if (ctrl.rOut || ctrl.baOut)
                        bus = regBus;
                else if (ctrl.cOut)
                        bus = cExt;
                else
                        bus = '0;
        end

        regFile rf_i (
                .Clock  (Clock),
                .rst    (rst),
                .ir     (ir),
                .gra    (ctrl.gra),
                .grb    (ctrl.grb),
                .grc    (ctrl.grc),
                .rIn    (ctrl.rIn),
                .rOut   (ctrl.rOut),
                .baOut  (ctrl.baOut),
                .busIn  (bus),
                .busOut (regBus)
        );

        aluUnit alu_i (
                .yVal   (y),
                .busVal (bus),
                .aluSel (ctrl.aluSel),
                .incPc  (ctrl.incPc),
                .result (aluRes)
        );

        shiftUnit shift_i (
                .yVal   (y),
                .busVal (bus),
                .aluSel (ctrl.aluSel),
                .result (shiftRes)
        );

        always_comb begin
                condMet = 1'b0;
                unique case (cond)
                        condZero:    condMet = (bus == '0);
                        condNonzero: condMet = (bus != '0);
                        condPlus:    condMet = !bus[31];
                        condMinus:   condMet = bus[31];
                endcase
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        pc <= '0;
                        outPort <= '0;
                        outStrobe <= 1'b0;
                        brFlag <= 1'b0;
                end else begin
                        outStrobe <= ctrl.outIn;
                        if (ctrl.conIn)
                                brFlag <= condMet;
                        // only the branch step loads PC without read
                        if (ctrl.pcIn && (ctrl.read || brFlag))
                                pc <= bus;
                        if (ctrl.outIn)
                                outPort <= bus;
                end
        end

        always_ff @(posedge Clock) begin
                if (ctrl.marIn)
                        mar <= bus[ADDR_W-1:0];
                if (ctrl.mdrIn)
                        mdr <= ctrl.read ? memRData : bus;
                if (ctrl.irIn)
                        ir <= bus;
                if (ctrl.yIn)
                        y <= bus;
                if (ctrl.zIn)
                        z <= ctrl.aluSel[3] ? shiftRes : aluRes;  // group bit picks unit
        end

endmodule

// File: ctrlSeq.sv
`timescale 1ns/1ps
module ctrlSeq (
        input  logic Clock,
        input  logic rst,
        input  cpuIsa::instrWord_u ir,
        output cpuCtrl::ctrlWord_t ctrl,
        output logic halted
);
        import cpuIsa::*;
        import cpuCtrl::*;

        logic [2:0] step;
        logic [7:0] t;
        logic started;
        opcode_e op;
        logic aluOp, immOp, isLdi, unary, memOp;
        logic isLd, isSt, isBr, isOut, isHalt, known;
        logic lastStep;
        logic haltNow;
        ctrlWord_t word;

        function automatic aluSel_e selFor(opcode_e code);
                case (code)
                        sub:          return selSub;
                        andOp, andi:  return selAnd;
                        orOp, ori:    return selOr;
                        shr:          return selShr;
                        shra:         return selShra;
                        shl:          return selShl;
                        ror:          return selRor;
                        rol:          return selRol;
                        neg:          return selNeg;
                        notOp:        return selNot;
                        default:      return selAdd;    // address and branch sums too
                endcase
        endfunction

        assign op = ir.rForm.op;
        assign t = 8'd1 << step;        // one-hot T0..T7

        assign immOp = op inside {addi, andi, ori, ldi};
        assign isLdi = (op == ldi);
        assign aluOp = immOp || (op inside {add, sub, andOp, orOp, shr, shra, shl, ror, rol});
        assign unary = op inside {neg, notOp};
        assign isLd = (op == ld);
        assign isSt = (op == st);
        assign memOp = isLd || isSt;
        assign isBr = (op == br);
        assign isOut = (op == outOp);
        assign isHalt = (op == halt);
        assign known = aluOp || unary || memOp || isBr || isOut || isHalt;

        // fetch in T0..T2, then per-class decode
        always_comb begin
                word.pcOut   = t[0] || (t[4] && isBr);
                word.zLowOut = t[1] || (t[5] && (aluOp || memOp)) || (t[4] && unary)
                               || (t[6] && isBr);
                word.mdrOut  = t[2] || (t[7] && isLd);
                word.rOut    = (t[3] && ((aluOp && !isLdi) || unary || isBr || isOut))
                               || (t[4] && aluOp && !immOp) || (t[6] && isSt);
                word.cOut    = (t[4] && (immOp || memOp)) || (t[5] && isBr);
                word.gra     = (t[3] && (isBr || isOut)) || (t[4] && unary)
                               || (t[5] && aluOp) || (t[6] && isSt) || (t[7] && isLd);
                word.grb     = t[3] && (aluOp || unary || memOp);
                word.grc     = t[4] && aluOp && !immOp;
                word.baOut   = t[3] && (isLdi || memOp);
                word.rIn     = (t[5] && aluOp) || (t[4] && unary) || (t[7] && isLd);
                word.marIn   = t[0] || (t[5] && memOp);
                word.mdrIn   = t[1] || (t[6] && memOp);
                word.pcIn    = t[1] || (t[6] && isBr);
                word.irIn    = t[2];
                word.yIn     = (t[3] && (aluOp || memOp)) || (t[4] && isBr);
                word.zIn     = t[0] || (t[3] && unary) || (t[4] && (aluOp || memOp))
                               || (t[5] && isBr);
                word.incPc   = t[0];
                word.read    = t[1] || (t[6] && isLd);
                word.write   = t[7] && isSt;
                word.conIn   = t[3] && isBr;
                word.outIn   = t[3] && isOut;
                word.aluSel  = (step < 3'd3) ? selAdd : selFor(op);
        end

        assign lastStep = (t[3] && (isOut || !known)) || (t[4] && unary)
                          || (t[5] && aluOp) || (t[6] && isBr) || (t[7] && memOp);
        assign haltNow = t[3] && isHalt;

        always_comb begin
                ctrl = '0;
                if (started && !halted)
                        ctrl = word;
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        step <= 3'd0;
                        started <= 1'b0;
                        halted <= 1'b0;
                end else begin
                        started <= 1'b1;
                        if (started && !halted) begin
                                if (haltNow)
                                        halted <= 1'b1;         // counter freezes here
                                else if (lastStep)
                                        step <= 3'd0;
                                else
                                        step <= step + 3'd1;
                        end
                end
        end

endmodule

// File: cpuTop.sv
`timescale 1ns/1ps
module cpuTop #(
        parameter int MEM_DEPTH = 256
) (
        input  logic Clock,
        input  logic rst,
        input  logic loadEn,
        input  logic [$clog2(MEM_DEPTH)-1:0] loadAddr,
        input  logic [31:0] loadData,
        output logic [31:0] outPort,
        output logic outStrobe,
        output logic halted
);
        import cpuIsa::*;
        import cpuCtrl::*;

        ctrlWord_t ctrl;
        instrWord_u ir;
        logic [$clog2(MEM_DEPTH)-1:0] memAddr;
        logic [31:0] memWData;
        logic [31:0] memRData;

        ctrlSeq seq_i (
                .Clock  (Clock),
                .rst    (rst),
                .ir     (ir),
                .ctrl   (ctrl),
                .halted (halted)
        );

        dataPath #(.MEM_DEPTH(MEM_DEPTH)) dp_i (
                .Clock     (Clock),
                .rst       (rst),
                .ctrl      (ctrl),
                .ir        (ir),
                .memAddr   (memAddr),
                .memWData  (memWData),
                .memRData  (memRData),
                .outPort   (outPort),
                .outStrobe (outStrobe)
        );

        ramBlock #(.MEM_DEPTH(MEM_DEPTH)) ram_i (
                .Clock    (Clock),
                .rst      (rst),
                .addr     (memAddr),
                .wData    (memWData),
                .write    (ctrl.write),
                .rData    (memRData),
                .loadEn   (loadEn),
                .loadAddr (loadAddr),
                .loadData (loadData)
        );

endmodule

// File: cpuChecker.sv
`timescale 1ns/1ps
module cpuChecker (
        input  logic Clock,
        input  logic rst,
        input  logic start,
        input  logic report,
        input  cpuIsa::opcode_e op,
        input  logic [31:0] opA,
        input  logic [31:0] opB,
        input  logic [31:0] outPort,
        input  logic outStrobe,
        input  logic halted,
        output int errCount,
        output int testCount
);
        import cpuIsa::*;

        logic [31:0] expQ [$];  // outputs still owed by the program
        logic [31:0] want;
        logic active;
        int testErrs;
        int passCount;
        opcode_e curOp;

        function automatic logic [31:0] expected(opcode_e code, logic [31:0] a, logic [31:0] b);
                logic [4:0] n;
                logic [31:0] c;
                n = b[4:0];
                c = {{13{b[18]}}, b[18:0]};     // sign-extended 19-bit constant
                case (code)
                        add:   return a + b;
                        sub:   return a - b;
                        andOp: return a & b;
                        orOp:  return a | b;
                        shr:   return a >> n;
                        shra:  return (a >> n) | (a[31] ? ~(32'hFFFFFFFF >> n) : 32'd0);
                        shl:   return a << n;
                        ror:   return (n == 5'd0) ? a : ((a >> n) | (a << (6'd32 - n)));
                        rol:   return (n == 5'd0) ? a : ((a << n) | (a >> (6'd32 - n)));
                        addi:  return a + c;
                        andi:  return a & c;
                        ori:   return a | c;
                        ldi:   return c;                // base is R0
                        neg:   return 32'd0 - a;
                        notOp: return ~a;
                        default: return a;              // store then load gives A back
                endcase
        endfunction

        function automatic logic branchTaken(logic [31:0] a, logic [1:0] cond);
                case (brCond_e'(cond))
                        condZero:    return a == 32'd0;
                        condNonzero: return a != 32'd0;
                        condPlus:    return !a[31];
                        default:     return a[31];
                endcase
        endfunction

        task automatic checkStrobe();
                if (expQ.size() == 0) begin
                        $display("Error at %0d ns: extra output strobe, outPort %h",
                                 $time, outPort);
                        testErrs++;
                end else begin
                        want = expQ.pop_front();
                        if (outPort !== want) begin
                                $display("Mismatch at %0d ns: outPort expected %h actual %h",
                                         $time, want, outPort);
                                testErrs++;
                        end
                end
        endtask

        initial begin
                errCount = 0;
                testCount = 0;
                passCount = 0;
                testErrs = 0;
                active = 1'b0;
                curOp = add;
        end

        always @(posedge Clock) begin
                if (start) begin
                        expQ.delete();
                        curOp = op;
                        testErrs = 0;
                        active = 1'b1;
                        if (op == br) begin
                                if (!branchTaken(opA, opB[1:0]))
                                        expQ.push_back(opA);
                                expQ.push_back(32'd0);  // the out R0 after the target
                        end else begin
                                expQ.push_back(expected(op, opA, opB));
                        end
                end else if (active && !rst) begin
                        if (outStrobe)
                                checkStrobe();
                        if (halted) begin
                                if (expQ.size() != 0) begin
                                        $display("Error: halted with %0d output strobes missing",
                                                 expQ.size());
                                        testErrs++;
                                end
                                $display("test %0d %s: %s", testCount, curOp.name(),
                                         (testErrs == 0) ? "pass" : "fail");
                                errCount += testErrs;
                                if (testErrs == 0)
                                        passCount++;
                                testCount++;
                                active = 1'b0;
                        end
                end else if (outStrobe && !rst) begin
                        $display("Error at %0d ns: output strobe outside a running test", $time);
                        errCount++;
                end
                if (report)
                        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                                 testCount, passCount, testCount - passCount, errCount);
        end

endmodule

// File: cpuTb.sv
`timescale 1ns/1ps
module cpuTb;
        import cpuIsa::*;

        localparam int MEM_DEPTH = 256;
        localparam int ADDR_W = $clog2(MEM_DEPTH);
        localparam int NUM_ROWS = 47;

        typedef struct packed {
                opcode_e op;
                logic [31:0] a;
                logic [31:0] b;         // operand B or constant or branch condition
                logic rnd;
        } row_t;

        logic Clock;
        logic rst;
        logic loadEn;
        logic [ADDR_W-1:0] loadAddr;
        logic [31:0] loadData;
        logic [31:0] outPort;
        logic outStrobe;
        logic halted;
        logic start;
        logic report;
        opcode_e curOp;
        logic [31:0] curA;
        logic [31:0] curB;
        int errCount;
        int testCount;
        logic [31:0] lfsr;
        logic [ADDR_W-1:0] ldAddr [8];
        logic [31:0] ldData [8];
        int ldCount;

        cpuTop #(.MEM_DEPTH(MEM_DEPTH)) dut_i (
                .Clock     (Clock),
                .rst       (rst),
                .loadEn    (loadEn),
                .loadAddr  (loadAddr),
                .loadData  (loadData),
                .outPort   (outPort),
                .outStrobe (outStrobe),
                .halted    (halted)
        );

        cpuChecker chk_i (
                .Clock     (Clock),
                .rst       (rst),
                .start     (start),
                .report    (report),
                .op        (curOp),
                .opA       (curA),
                .opB       (curB),
                .outPort   (outPort),
                .outStrobe (outStrobe),
                .halted    (halted),
                .errCount  (errCount),
                .testCount (testCount)
        );

        function automatic row_t rowAt(int i);
                case (i)
                        0:  return '{add, 32'd5, 32'd7, 1'b0};
                        1:  return '{add, 32'd0, 32'd0, 1'b1};
                        2:  return '{sub, 32'd3, 32'd10, 1'b0};
                        3:  return '{sub, 32'd0, 32'd0, 1'b1};
                        4:  return '{andOp, 32'hF0F0F0F0, 32'h0FF00FF0, 1'b0};
                        5:  return '{andOp, 32'd0, 32'd0, 1'b1};
                        6:  return '{orOp, 32'hF0000000, 32'h0000000F, 1'b0};
                        7:  return '{orOp, 32'd0, 32'd0, 1'b1};
                        8:  return '{shr, 32'h80000001, 32'd1, 1'b0};
                        9:  return '{shr, 32'h80000000, 32'd31, 1'b0};
                        10: return '{shr, 32'hA5A5A5A5, 32'd0, 1'b0};
                        11: return '{shr, 32'd0, 32'd0, 1'b1};
                        12: return '{shra, 32'h80000010, 32'd4, 1'b0};
                        13: return '{shra, 32'h80000000, 32'd31, 1'b0};
                        14: return '{shra, 32'h80000001, 32'd0, 1'b0};
                        15: return '{shra, 32'hC0000000, 32'd1, 1'b0};
                        16: return '{shra, 32'd0, 32'd0, 1'b1};
                        17: return '{shl, 32'hFFFFFFFF, 32'd0, 1'b0};
                        18: return '{shl, 32'h00000003, 32'd31, 1'b0};
                        19: return '{shl, 32'h40000001, 32'd1, 1'b0};
                        20: return '{shl, 32'd0, 32'd0, 1'b1};
                        21: return '{ror, 32'h12345678, 32'd1, 1'b0};
                        22: return '{ror, 32'h12345678, 32'd0, 1'b0};
                        23: return '{ror, 32'h80000001, 32'd31, 1'b0};
                        24: return '{ror, 32'd0, 32'd0, 1'b1};
                        25: return '{rol, 32'h80000001, 32'd1, 1'b0};
                        26: return '{rol, 32'h12345678, 32'd0, 1'b0};
                        27: return '{rol, 32'h80000001, 32'd31, 1'b0};
                        28: return '{rol, 32'd0, 32'd0, 1'b1};
                        29: return '{addi, 32'd100, 32'h0007FFFF, 1'b0};   // constant -1
                        30: return '{addi, 32'd0, 32'd0, 1'b1};
                        31: return '{andi, 32'hFFFFFFFF, 32'h00040000, 1'b0};
                        32: return '{ori, 32'd0, 32'h00000123, 1'b0};
                        33: return '{ldi, 32'd0, 32'h0007FFF0, 1'b0};
                        34: return '{ldi, 32'd0, 32'd0, 1'b1};
                        35: return '{neg, 32'd5, 32'd0, 1'b0};
                        36: return '{neg, 32'd0, 32'd0, 1'b1};
                        37: return '{notOp, 32'h0F0F0F0F, 32'd0, 1'b0};
                        38: return '{notOp, 32'd0, 32'd0, 1'b1};
                        39: return '{st, 32'hCAFEF00D, 32'd0, 1'b0};
                        40: return '{st, 32'd0, 32'd0, 1'b1};
                        41: return '{br, 32'd0, 32'd0, 1'b0};      // zero condition holds
                        42: return '{br, 32'd5, 32'd0, 1'b0};
                        43: return '{br, 32'd5, 32'd1, 1'b0};
                        44: return '{br, 32'h80000000, 32'd2, 1'b0};
                        45: return '{br, 32'h80000000, 32'd3, 1'b0};
                        46: return '{br, 32'd0, 32'd0, 1'b1};
                        default: return '{halt, 32'd0, 32'd0, 1'b0};
                endcase
        endfunction

        function automatic logic [31:0] lfsrNext(logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        task automatic drawBits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsrNext(lfsr);
                        v = {v[30:0], lfsr[0]};
                end
        endtask

        function automatic int bWidth(opcode_e code);
                if (code inside {addi, andi, ori, ldi})
                        return 19;
                if (code == br)
                        return 2;       // condition only
                return 32;
        endfunction

        function automatic logic [31:0] rWord(opcode_e op, logic [3:0] ra, logic [3:0] rb,
                                              logic [3:0] rc);
                return {op, ra, rb, rc, 15'd0};
        endfunction

        function automatic logic [31:0] iWord(opcode_e op, logic [3:0] ra, logic [3:0] rb,
                                              logic [18:0] imm);
                return {op, ra, rb, imm};
        endfunction

        task automatic addWord(input int addr, input logic [31:0] data);
                ldAddr[ldCount] = ADDR_W'(addr);
                ldData[ldCount] = data;
                ldCount++;
        endtask

        task automatic buildProgram(input row_t r);
                ldCount = 0;
                addWord(64, r.a);
                case (r.op)
                        st: begin
                                addWord(70, ~r.a);      // clears what an earlier test left
                                addWord(0, iWord(ldi, 4'd0, 4'd0, 19'd5));
                                addWord(1, iWord(ld, 4'd1, 4'd0, 19'd64));
                                addWord(2, iWord(st, 4'd1, 4'd0, 19'd70));
                                addWord(3, iWord(ld, 4'd3, 4'd0, 19'd70));
                                addWord(4, rWord(outOp, 4'd3, 4'd0, 4'd0));
                                addWord(5, rWord(halt, 4'd0, 4'd0, 4'd0));
                        end
                        br: begin
                                addWord(0, iWord(ld, 4'd1, 4'd0, 19'd64));
                                addWord(1, iWord(br, 4'd1, {2'b00, r.b[1:0]}, 19'd1));
                                addWord(2, rWord(outOp, 4'd1, 4'd0, 4'd0));  // skipped if taken
                                addWord(3, rWord(outOp, 4'd0, 4'd0, 4'd0));
                                addWord(4, rWord(halt, 4'd0, 4'd0, 4'd0));
                        end
                        default: begin
                                addWord(65, r.b);
                                addWord(0, iWord(ld, 4'd1, 4'd0, 19'd64));
                                addWord(1, iWord(ld, 4'd2, 4'd0, 19'd65));
                                if (r.op inside {addi, andi, ori})
                                        addWord(2, iWord(r.op, 4'd3, 4'd1, r.b[18:0]));
                                else if (r.op == ldi)
                                        addWord(2, iWord(ldi, 4'd3, 4'd0, r.b[18:0]));
                                else if (r.op inside {neg, notOp})
                                        addWord(2, rWord(r.op, 4'd3, 4'd1, 4'd0));
                                else
                                        addWord(2, rWord(r.op, 4'd3, 4'd1, 4'd2));
                                addWord(3, rWord(outOp, 4'd3, 4'd0, 4'd0));
                                addWord(4, rWord(halt, 4'd0, 4'd0, 4'd0));
                        end
                endcase
        endtask

        initial begin
                Clock = 1'b0;
                forever #50 Clock = ~Clock;
        end

        initial begin
                #(NUM_ROWS * 120 * 100);
                $display("Timeout: run did not finish within %0d cycles", NUM_ROWS * 120);
                $display("ERRORS FOUND");
                $finish;
        end

        initial begin
                row_t r;
                lfsr = 32'd31567;
                rst = 1'b1;
                loadEn = 1'b0;
                loadAddr = '0;
                loadData = '0;
                start = 1'b0;
                report = 1'b0;
                curOp = add;
                curA = '0;
                curB = '0;
                for (int i = 0; i < NUM_ROWS; i++) begin
                        r = rowAt(i);
                        if (r.rnd) begin
                                drawBits(32, r.a);
                                drawBits(bWidth(r.op), r.b);
                        end
                        buildProgram(r);
                        for (int k = 0; k < 8; k++) begin       // 8 reset cycles double as load
                                @(negedge Clock);
                                rst = 1'b1;
                                loadEn = (k < ldCount);
                                loadAddr = (k < ldCount) ? ldAddr[k] : '0;
                                loadData = (k < ldCount) ? ldData[k] : '0;
                        end
                        @(negedge Clock);
                        rst = 1'b0;
                        loadEn = 1'b0;
                        start = 1'b1;
                        curOp = r.op;
                        curA = r.a;
                        curB = r.b;
                        @(negedge Clock);
                        start = 1'b0;
                        while (!halted)
                                @(negedge Clock);
                end
                @(negedge Clock);
                report = 1'b1;
                @(negedge Clock);
                report = 1'b0;
                @(negedge Clock);
                if (errCount == 0 && testCount == NUM_ROWS)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

// File: list.f
cpuIsa.sv
cpuCtrl.sv
regFile.sv
aluUnit.sv
shiftUnit.sv
ramBlock.sv
dataPath.sv
ctrlSeq.sv
cpuTop.sv
cpuChecker.sv
cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpuTb -f list.f

simOut=$(./obj_dir/VcpuTb)
echo "$simOut"

# pass only when the testbench printed its pass line
echo "$simOut" | grep -qx "NO ERRORS"
